/* source/tpl_dac_macros.svh */
// *******************************************************************
// Link geometry shared by the packages and the RTL of the DAC
// transport layer, included wherever a width or count is needed
// *******************************************************************

`ifndef TPL_DAC_MACROS_SVH
`define TPL_DAC_MACROS_SVH

// Number of JESD204 lanes, each carrying one 32-bit word per clock
`define TPL_NUM_LANES 4

// Number of DAC channels fed into the framer
`define TPL_NUM_CHANNELS 2

// Samples per channel per clock
// Channels x samples x 16 must equal lanes x 32
`define TPL_DATA_PATH_WIDTH 4

`endif

/* source/tpl_dac_data_pkg.sv */
// *******************************************************************
// Sample, channel beat and lane word types of the DAC datapath,
// used by every block between the sources and the link
// *******************************************************************

`include "tpl_dac_macros.svh"

package tpl_dac_data_pkg;

  // One 16-bit DAC sample
  typedef logic [15:0] sample_t;

  // One 32-bit word on one lane
  typedef logic [31:0] lane_word_t;

  // All samples of one channel for one clock
  // Sample 0 is the oldest and sits in the low bits
  typedef struct packed {
    sample_t [`TPL_DATA_PATH_WIDTH-1:0] smp;
  } chan_beat_t;

  // All lanes for one clock, lane 0 in the low bits
  typedef lane_word_t [`TPL_NUM_LANES-1:0] link_beat_t;

endpackage

/* source/tpl_dac_cfg_pkg.sv */
// *******************************************************************
// Per-channel configuration of the DAC transport layer: source
// select and the ramp and pattern settings, static between tests
// *******************************************************************

package tpl_dac_cfg_pkg;

  // Channel data source
  // Codes above SRC_PN15 are unused and give zero samples
  typedef enum logic [2:0] {
    SRC_DMA     = 3'd0,
    SRC_RAMP    = 3'd1,
    SRC_PATTERN = 3'd2,
    SRC_PN7     = 3'd3,
    SRC_PN15    = 3'd4
  } dac_src_e;

  // Configuration of one channel, 67 bits
  typedef struct packed {
    // Source select
    dac_src_e                  src;
    // Ramp start value loaded on sync
    tpl_dac_data_pkg::sample_t ramp_init;
    // Ramp step between neighbouring samples
    tpl_dac_data_pkg::sample_t ramp_incr;
    // Pattern words, alternated beat by beat
    tpl_dac_data_pkg::sample_t pat_0;
    tpl_dac_data_pkg::sample_t pat_1;
  } chan_cfg_t;

endpackage

/* source/tpl_dac_pn_gen.sv */
// *******************************************************************
// PN7 and PN15 test sequence generator shared by all channels
// Presents one full beat of each sequence per clock
// *******************************************************************

`timescale 1ns/1ps
`include "tpl_dac_macros.svh"

module tpl_dac_pn_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         advance,
  input  logic                         sync,
  output tpl_dac_data_pkg::chan_beat_t pn7_beat,
  output tpl_dac_data_pkg::chan_beat_t pn15_beat
);

  // Serial bits consumed per beat
  localparam int BEAT_BITS = `TPL_DATA_PATH_WIDTH * 16;
  localparam logic [6:0]  PN7_SEED  = 7'h7f;
  localparam logic [14:0] PN15_SEED = 15'h7fff;

  logic [6:0]  pn7_state;
  logic [6:0]  pn7_next;
  logic [14:0] pn15_state;
  logic [14:0] pn15_next;

  // Unrolled serial walk, x^7+x^6+1 and x^15+x^14+1
  // Each step's feedback bit is the serial output
  // First bit of the beat lands in the MSB of sample 0
  always_comb begin : p_walk
    logic fb7;
    logic fb15;
    pn7_next  = pn7_state;
    pn15_next = pn15_state;
    pn7_beat  = '0;
    pn15_beat = '0;
    for (int i = 0; i < BEAT_BITS; i++) begin
      fb7       = pn7_next[6] ^ pn7_next[5];
      fb15      = pn15_next[14] ^ pn15_next[13];
      pn7_next  = {pn7_next[5:0], fb7};
      pn15_next = {pn15_next[13:0], fb15};
      pn7_beat.smp[i / 16][15 - (i % 16)]  = fb7;
      pn15_beat.smp[i / 16][15 - (i % 16)] = fb15;
    end
  end

  // Sync reseeds, the beat after a sync starts from the seed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_state  <= PN7_SEED;
      pn15_state <= PN15_SEED;
    end else if (advance) begin
      pn7_state  <= sync ? PN7_SEED : pn7_next;
      pn15_state <= sync ? PN15_SEED : pn15_next;
    end
  end

  // A zero state would lock the LFSRs for good
  a_pn_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    (pn7_state != '0) && (pn15_state != '0));

endmodule

/* source/tpl_dac_channel.sv */
// *******************************************************************
// One DAC channel: ramp tone, pattern and PN/DMA source select into
// a registered beat, one instance per channel in the core
// *******************************************************************

`timescale 1ns/1ps
`include "tpl_dac_macros.svh"

module tpl_dac_channel (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         advance,
  input  logic                         sync,
  input  tpl_dac_cfg_pkg::chan_cfg_t   cfg,
  input  tpl_dac_data_pkg::chan_beat_t dma_beat,
  input  tpl_dac_data_pkg::chan_beat_t pn7_beat,
  input  tpl_dac_data_pkg::chan_beat_t pn15_beat,
  output logic                         dma_req,
  output tpl_dac_data_pkg::chan_beat_t chan_beat
);

  import tpl_dac_data_pkg::*;
  import tpl_dac_cfg_pkg::*;

  // Ramp phase of sample 0 in the current beat
  sample_t    ramp_acc;
  // Low selects pat_0, high selects pat_1
  logic       pat_sel;
  chan_beat_t ramp_beat;
  chan_beat_t pat_beat;
  chan_beat_t src_beat;

  // ******************************************************************
  // Source generation
  // ******************************************************************

  // Sample k is acc + k * incr, wrapping at 16 bits
  always_comb begin : p_ramp
    for (int k = 0; k < `TPL_DATA_PATH_WIDTH; k++) begin
      ramp_beat.smp[k] = ramp_acc + sample_t'(k) * cfg.ramp_incr;
    end
  end

  // Whole beat carries one pattern word
  always_comb begin : p_pattern
    for (int k = 0; k < `TPL_DATA_PATH_WIDTH; k++) begin
      pat_beat.smp[k] = pat_sel ? cfg.pat_1 : cfg.pat_0;
    end
  end

  // Sync restarts the ramp at ramp_init and the pattern at pat_0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ramp_acc <= '0;
      pat_sel  <= 1'b0;
    end else if (advance) begin
      if (sync) begin
        ramp_acc <= cfg.ramp_init;
        pat_sel  <= 1'b0;
      end else begin
        ramp_acc <= ramp_acc + sample_t'(`TPL_DATA_PATH_WIDTH) * cfg.ramp_incr;
        pat_sel  <= ~pat_sel;
      end
    end
  end

  // ******************************************************************
  // Source select and output register
  // ******************************************************************

  always_comb begin : p_select
    case (cfg.src)
      SRC_DMA:     src_beat = dma_beat;
      SRC_RAMP:    src_beat = ramp_beat;
      SRC_PATTERN: src_beat = pat_beat;
      SRC_PN7:     src_beat = pn7_beat;
      SRC_PN15:    src_beat = pn15_beat;
      // Unused codes send silence
      default:     src_beat = '0;
    endcase
  end

  // DMA data is taken on the same clock as the request
  assign dma_req = advance && (cfg.src == SRC_DMA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chan_beat <= '0;
    end else if (advance) begin
      chan_beat <= src_beat;
    end
  end

  // Back-pressure freezes the channel output
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !advance |=> $stable(chan_beat));

endmodule

/* source/tpl_dac_framer.sv */
// *******************************************************************
// Lane framer of the DAC transport layer, mapping channel beats onto
// lanes with the high octet of every sample first and flagging valid
// *******************************************************************

`timescale 1ns/1ps
`include "tpl_dac_macros.svh"

module tpl_dac_framer (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  advance,
  input  tpl_dac_data_pkg::chan_beat_t [`TPL_NUM_CHANNELS-1:0] chan_beats,
  output tpl_dac_data_pkg::link_beat_t                          link_data,
  output logic                                                  link_valid
);

  import tpl_dac_data_pkg::*;

  localparam int CHAN_BITS = `TPL_NUM_CHANNELS * `TPL_DATA_PATH_WIDTH * 16;
  localparam int LINK_BITS = `TPL_NUM_LANES * 32;

  // Channel data must fill the lanes exactly
  if (CHAN_BITS != LINK_BITS) begin : g_width_check
    $error("Channel beat width does not match lane width");
  end

  // Channel 0 in the low bits
  logic [CHAN_BITS-1:0] chan_flat;
  link_beat_t           mapped;
  // Counts advances up to two and then saturates
  logic [1:0]           fill_cnt;

  assign chan_flat = chan_beats;

  // Lane l takes bits 32l+31..32l with each sample octet-swapped
  always_comb begin : p_map
    sample_t raw;
    for (int l = 0; l < `TPL_NUM_LANES; l++) begin
      for (int h = 0; h < 2; h++) begin
        raw = chan_flat[32*l + 16*h +: 16];
        mapped[l][16*h +: 16] = {raw[7:0], raw[15:8]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_data <= '0;
      fill_cnt  <= '0;
    end else if (advance) begin
      link_data <= mapped;
      if (fill_cnt != 2'd2) begin
        fill_cnt <= fill_cnt + 2'd1;
      end
    end
  end

  // Valid once both pipeline stages hold source data
  assign link_valid = (fill_cnt == 2'd2);

endmodule

/* source/tpl_dac_core.sv */
// *******************************************************************
// Top of the DAC transport layer: PN generator, channel sources and
// framer, advanced by link_ready and realigned by dac_sync
// *******************************************************************

`timescale 1ns/1ps
`include "tpl_dac_macros.svh"

module tpl_dac_core (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 dac_sync,
  input  logic                                                 link_ready,
  input  tpl_dac_cfg_pkg::chan_cfg_t   [`TPL_NUM_CHANNELS-1:0] chan_cfg,
  input  tpl_dac_data_pkg::chan_beat_t [`TPL_NUM_CHANNELS-1:0] dac_ddata,
  output logic                         [`TPL_NUM_CHANNELS-1:0] dac_valid,
  output tpl_dac_data_pkg::link_beat_t                         link_data,
  output logic                                                 link_valid
);

  import tpl_dac_data_pkg::*;

  // Shared PN beats, fanned out to every channel
  chan_beat_t                         pn7_beat;
  chan_beat_t                         pn15_beat;
  // Registered channel beats into the framer
  chan_beat_t [`TPL_NUM_CHANNELS-1:0] chan_beats;

  // ******************************************************************
  // PN sources
  // ******************************************************************

  tpl_dac_pn_gen i_pn_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (link_ready),
    .sync      (dac_sync),
    .pn7_beat  (pn7_beat),
    .pn15_beat (pn15_beat)
  );

  // ******************************************************************
  // Channels, one DMA request bit each
  // ******************************************************************

  for (genvar i = 0; i < `TPL_NUM_CHANNELS; i++) begin : g_channel
    tpl_dac_channel i_channel (
      .clk       (clk),
      .rst_n     (rst_n),
      .advance   (link_ready),
      .sync      (dac_sync),
      .cfg       (chan_cfg[i]),
      .dma_beat  (dac_ddata[i]),
      .pn7_beat  (pn7_beat),
      .pn15_beat (pn15_beat),
      .dma_req   (dac_valid[i]),
      .chan_beat (chan_beats[i])
    );
  end

  // Lane mapping, second pipeline stage
  tpl_dac_framer i_framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (link_ready),
    .chan_beats (chan_beats),
    .link_data  (link_data),
    .link_valid (link_valid)
  );

endmodule

/* verif/tpl_dac_tb.sv */
// *******************************************************************
// Testbench of the DAC transport layer: runs DMA, ramp, pattern, PN,
// back-pressure and reset tests against a model of the sources
// *******************************************************************

`timescale 1ns/1ps
`include "tpl_dac_macros.svh"

module tpl_dac_tb;

  import tpl_dac_data_pkg::*;
  import tpl_dac_cfg_pkg::*;

  localparam int NCH = `TPL_NUM_CHANNELS;
  localparam int DPW = `TPL_DATA_PATH_WIDTH;
  // Test lengths in clock cycles
  localparam int LEN_RESET  = 4;
  localparam int LEN_DMA    = 40;
  localparam int LEN_RAMP   = 40;
  localparam int LEN_PN     = 100;
  localparam int LEN_BP     = 120;
  localparam int LEN_UNUSED = 40;
  localparam int TOTAL_CYCLES =
    2 * LEN_RESET + LEN_DMA + LEN_RAMP + LEN_PN + LEN_BP + LEN_UNUSED;
  // Margin covers the sync pulses between tests
  localparam int WATCHDOG_NS = TOTAL_CYCLES * 4 + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 dac_sync;
  logic                 link_ready;
  chan_cfg_t  [NCH-1:0] chan_cfg;
  chan_beat_t [NCH-1:0] dac_ddata;
  logic       [NCH-1:0] dac_valid;
  link_beat_t           link_data;
  logic                 link_valid;

  string       test_name;
  logic [31:0] lcg_state;

  // ******************************************************************
  // Reference model state
  // ******************************************************************

  // Channel stage, then framed link word
  chan_beat_t [NCH-1:0] m_stage;
  link_beat_t           exp_link;
  logic                 exp_valid;
  logic       [NCH-1:0] exp_req;
  int                   m_fill;
  sample_t              m_ramp [NCH];
  logic                 m_pat  [NCH];
  // Serial history, oldest bit at index 0
  bit                   pn7_hist[$];
  bit                   pn15_hist[$];

  tpl_dac_core i_tpl_dac_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .dac_sync   (dac_sync),
    .link_ready (link_ready),
    .chan_cfg   (chan_cfg),
    .dac_ddata  (dac_ddata),
    .dac_valid  (dac_valid),
    .link_data  (link_data),
    .link_valid (link_valid)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic chan_beat_t random_beat();
    chan_beat_t  b;
    logic [31:0] r;
    for (int k = 0; k < DPW; k++) begin
      r = lcg_next();
      b.smp[k] = r[31:16];
    end
    return b;
  endfunction

  // Recurrence b[n] = b[n-N] ^ b[n-N+1], all-ones start
  task automatic seed_pn();
    pn7_hist.delete();
    pn15_hist.delete();
    repeat (7) pn7_hist.push_back(1'b1);
    repeat (15) pn15_hist.push_back(1'b1);
  endtask

  // Next 16 serial bits, first bit in the MSB
  function automatic sample_t pn_sample(bit long_seq);
    sample_t s;
    bit      b;
    for (int i = 15; i >= 0; i--) begin
      if (long_seq) begin
        b = pn15_hist[0] ^ pn15_hist[1];
        pn15_hist.push_back(b);
        void'(pn15_hist.pop_front());
      end else begin
        b = pn7_hist[0] ^ pn7_hist[1];
        pn7_hist.push_back(b);
        void'(pn7_hist.pop_front());
      end
      s[i] = b;
    end
    return s;
  endfunction

  // Sample n of the link goes to lane n/2, high octet first
  function automatic link_beat_t frame_beats(chan_beat_t [NCH-1:0] beats);
    link_beat_t lb;
    sample_t    s;
    int         idx;
    lb = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      for (int k = 0; k < DPW; k++) begin
        s   = beats[ch].smp[k];
        idx = ch * DPW + k;
        lb[idx / 2][16 * (idx % 2) +: 16] = {s[7:0], s[15:8]};
      end
    end
    return lb;
  endfunction

  task automatic reset_model();
    m_stage   = '0;
    exp_link  = '0;
    exp_valid = 1'b0;
    m_fill    = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      m_ramp[ch] = '0;
      m_pat[ch]  = 1'b0;
    end
    seed_pn();
  endtask

  // Advances only with link_ready, like the DUT pipeline
  always @(posedge clk or negedge rst_n) begin : p_model
    chan_beat_t pn7_b;
    chan_beat_t pn15_b;
    sample_t    v;
    if (!rst_n) begin
      reset_model();
    end else if (link_ready) begin
      for (int k = 0; k < DPW; k++) begin
        pn7_b.smp[k]  = pn_sample(1'b0);
        pn15_b.smp[k] = pn_sample(1'b1);
      end
      exp_link = frame_beats(m_stage);
      if (m_fill < 2) begin
        m_fill++;
      end
      exp_valid = (m_fill == 2);
      for (int ch = 0; ch < NCH; ch++) begin
        v = m_ramp[ch];
        for (int k = 0; k < DPW; k++) begin
          case (chan_cfg[ch].src)
            SRC_DMA:     m_stage[ch].smp[k] = dac_ddata[ch].smp[k];
            SRC_RAMP:    m_stage[ch].smp[k] = v;
            SRC_PATTERN: m_stage[ch].smp[k] = m_pat[ch] ? chan_cfg[ch].pat_1
                                                        : chan_cfg[ch].pat_0;
            SRC_PN7:     m_stage[ch].smp[k] = pn7_b.smp[k];
            SRC_PN15:    m_stage[ch].smp[k] = pn15_b.smp[k];
            default:     m_stage[ch].smp[k] = '0;
          endcase
          v = v + chan_cfg[ch].ramp_incr;
        end
        m_ramp[ch] = dac_sync ? chan_cfg[ch].ramp_init : v;
        m_pat[ch]  = dac_sync ? 1'b0 : !m_pat[ch];
      end
      if (dac_sync) begin
        seed_pn();
      end
    end
  end

  // DMA request follows ready for DMA channels only
  always_comb begin : p_exp_req
    for (int ch = 0; ch < NCH; ch++) begin
      exp_req[ch] = link_ready && (chan_cfg[ch].src == SRC_DMA);
    end
  end

  // ******************************************************************
  // Checks
  // ******************************************************************

  task automatic fail_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_error(string what, logic [127:0] expected, logic [127:0] actual);
    $display("** Error: test %s, %s expected %h, actual %h", test_name, what, expected, actual);
    fail_run();
  endtask

  a_link_data: assert property (@(posedge clk) disable iff (!rst_n) link_data == exp_link)
    else value_error("link_data", $sampled(exp_link), $sampled(link_data));

  a_link_valid: assert property (@(posedge clk) disable iff (!rst_n) link_valid == exp_valid)
    else value_error("link_valid", 128'($sampled(exp_valid)), 128'($sampled(link_valid)));

  a_dac_valid: assert property (@(posedge clk) disable iff (!rst_n) dac_valid == exp_req)
    else value_error("dac_valid", 128'($sampled(exp_req)), 128'($sampled(dac_valid)));

  // Pipeline still empty after reset
  a_zero_fill: assert property (@(posedge clk) disable iff (!rst_n)
    !link_valid |-> link_data == '0)
    else value_error("link_data before valid", 128'(0), $sampled(link_data));

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !link_ready |=> $stable(link_data))
    else begin
      $display("Error: test %s, link_data moved while link_ready was low", test_name);
      fail_run();
    end

  // ******************************************************************
  // Clock, stimulus and watchdog
  // ******************************************************************

  initial begin : p_clock
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic configure(int ch, dac_src_e src, sample_t init, sample_t incr,
                           sample_t p0, sample_t p1);
    chan_cfg[ch] <= '{src, init, incr, p0, p1};
  endtask

  task automatic pulse_sync();
    @(posedge clk);
    dac_sync   <= 1'b1;
    link_ready <= 1'b1;
  endtask

  // New DMA data every cycle, ready either held high or random
  task automatic run_cycles(int n, bit random_ready);
    logic [31:0] r;
    repeat (n) begin
      @(posedge clk);
      r = lcg_next();
      dac_sync   <= 1'b0;
      link_ready <= random_ready ? r[29] : 1'b1;
      for (int ch = 0; ch < NCH; ch++) begin
        dac_ddata[ch] <= random_beat();
      end
    end
  endtask

  initial begin : p_stimulus
    lcg_state  = 32'd83;
    test_name  = "reset";
    rst_n      = 1'b0;
    dac_sync   = 1'b0;
    link_ready = 1'b0;
    chan_cfg   = '0;
    dac_ddata  = '0;
    repeat (LEN_RESET) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "dma_passthrough";
    configure(0, SRC_DMA, '0, '0, '0, '0);
    configure(1, SRC_DMA, '0, '0, '0, '0);
    run_cycles(LEN_DMA, 1'b0);

    // Step chosen so the ramp wraps within the test
    test_name = "ramp_pattern";
    configure(0, SRC_RAMP, 16'h1234, 16'h0f37, '0, '0);
    configure(1, SRC_PATTERN, '0, '0, 16'ha5c3, 16'h3c5a);
    pulse_sync();
    run_cycles(LEN_RAMP, 1'b0);

    test_name = "pn_sequences";
    configure(0, SRC_PN7, '0, '0, '0, '0);
    configure(1, SRC_PN15, '0, '0, '0, '0);
    pulse_sync();
    run_cycles(LEN_PN / 2, 1'b0);
    pulse_sync();
    run_cycles(LEN_PN / 2, 1'b0);

    test_name = "back_pressure";
    configure(0, SRC_RAMP, 16'hff00, 16'h0101, '0, '0);
    configure(1, SRC_DMA, '0, '0, '0, '0);
    run_cycles(LEN_BP / 2, 1'b1);
    configure(1, SRC_PN15, '0, '0, '0, '0);
    pulse_sync();
    run_cycles(LEN_BP / 2, 1'b1);

    // Code 5 is outside the source enum
    test_name = "reset_unused_select";
    @(posedge clk);
    rst_n <= 1'b0;
    configure(0, dac_src_e'(3'd5), '0, '0, '0, '0);
    configure(1, SRC_DMA, '0, '0, '0, '0);
    repeat (LEN_RESET) @(posedge clk);
    rst_n <= 1'b1;
    run_cycles(LEN_UNUSED, 1'b1);

    @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

  initial begin : p_watchdog
    #(WATCHDOG_NS);
    $display("Timeout: test %s did not finish in time", test_name);
    fail_run();
  end

endmodule

/* src.f */
+incdir+source
source/tpl_dac_data_pkg.sv
source/tpl_dac_cfg_pkg.sv
source/tpl_dac_pn_gen.sv
source/tpl_dac_channel.sv
source/tpl_dac_framer.sv
source/tpl_dac_core.sv
verif/tpl_dac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the DAC transport layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f src.f --top-module tpl_dac_tb -o tpl_dac_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tpl_dac_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
